/* rob_defines.svh */
////////////////////////////////////////
// ROB_TAG_W must equal log2 of ROB_DEPTH
// CSR_SEL_W covers the four machine CSRs only
////////////////////////////////////////
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// Data and address width
`define XLEN        32

// Reorder buffer geometry
`define ROB_DEPTH   16
`define ROB_TAG_W   4

`define CSR_SEL_W   2   // mtvec, mepc, mcause, mscratch
`define REG_ADDR_W  5   // 32 architectural registers

`endif

/* rob_pkg.sv */
////////////////////////////////////////
// Types shared by the retirement pipeline
// Widths come from rob_defines.svh
////////////////////////////////////////
`include "rob_defines.svh"

package rob_pkg;

    typedef enum logic [1:0] {
        CLS_BRANCH,
        CLS_STORE,
        CLS_REG,     // Register-writing op or load
        CLS_SYSTEM
    } instr_class_e;

    // Bit 0 marks the two trapping system ops
    typedef enum logic [1:0] {
        SP_NONE,
        SP_ECALL,
        SP_MRET,
        SP_EBREAK
    } special_e;

    typedef enum logic [`CSR_SEL_W-1:0] {
        CSR_MTVEC,
        CSR_MEPC,
        CSR_MCAUSE,
        CSR_MSCRATCH
    } csr_sel_e;

    typedef enum logic [1:0] {
        SP_IDLE,
        SP_BUS,
        SP_DONE
    } store_state_e;

    localparam logic [7:0] MCAUSE_ILLEGAL = 8'd2;
    localparam logic [7:0] MCAUSE_BREAK   = 8'd3;
    localparam logic [7:0] MCAUSE_ECALL_U = 8'd8;
    localparam logic [7:0] MCAUSE_ECALL_M = 8'd11;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        instr_class_e           instr_class;
        special_e               special;
        logic [`REG_ADDR_W-1:0] reg_dest;
        logic                   csr_write;
        logic                   csr_read;
        csr_sel_e               csr_sel;
        logic                   branch_pred;   // Predicted taken
    } dispatch_t;

    typedef struct packed {
        logic [`ROB_TAG_W-1:0]  tag;
        logic [`XLEN-1:0]       value;         // Result, CSR data or store data
        logic [`XLEN-1:0]       destination;   // Branch target, CSR old value or store address
        logic                   branch_result; // Actually taken
        logic                   exception;
        logic [7:0]             mcause;
    } done_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        instr_class_e           instr_class;
        special_e               special;
        logic [`REG_ADDR_W-1:0] reg_dest;
        logic                   csr_write;
        logic                   csr_read;
        csr_sel_e               csr_sel;
        logic                   branch_pred;
        logic [`XLEN-1:0]       value;
        logic [`XLEN-1:0]       destination;
        logic                   branch_result;
        logic                   exception;
        logic [7:0]             mcause;
        logic                   ready;         // Completion has been merged
        logic [`ROB_TAG_W-1:0]  tag;
    } rob_entry_t;

    typedef struct packed {
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       write_data;
        logic                   csr_write;
        csr_sel_e               csr_sel;
        logic [`XLEN-1:0]       csr_data;
        logic                   trap;
        logic [7:0]             mcause;
        logic [`XLEN-1:0]       mepc;
        logic                   mret;
    } commit_t;

endpackage

/* reorder_buffer.sv */
////////////////////////////////////////
// Completions for tags not in flight are dropped
// A flush discards every entry at once
////////////////////////////////////////
`include "rob_defines.svh"

module reorder_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatch_valid,
    input  rob_pkg::dispatch_t    dispatch,
    input  logic                  done_valid,
    input  rob_pkg::done_t        done,
    input  logic                  dequeue,
    input  logic                  flush,
    output logic                  dispatch_ready,
    output logic [`ROB_TAG_W-1:0] dispatch_tag,
    output rob_pkg::rob_entry_t   head,
    output logic                  head_ready,
    output logic                  empty
);
    import rob_pkg::*;

    localparam logic [`ROB_TAG_W:0] FULL_COUNT = `ROB_DEPTH;

    rob_entry_t            entries [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] busy;       // Slot holds a live instruction
    logic [`ROB_TAG_W-1:0] head_ptr;
    logic [`ROB_TAG_W-1:0] tail_ptr;
    logic [`ROB_TAG_W:0]   count;
    logic                  alloc;
    logic                  merge;

    assign alloc = dispatch_valid && dispatch_ready;
    assign merge = done_valid && busy[done.tag];

    assign dispatch_ready = (count != FULL_COUNT);
    assign dispatch_tag   = tail_ptr;
    assign empty          = (count == '0);
    assign head           = entries[head_ptr];
    assign head_ready     = entries[head_ptr].ready && !empty;

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
            busy     <= '0;
        end else begin
            if (alloc) begin
                busy[tail_ptr] <= 1'b1;
                tail_ptr       <= tail_ptr + 1'b1;
            end
            if (dequeue) begin
                busy[head_ptr] <= 1'b0;
                head_ptr       <= head_ptr + 1'b1;
            end
            case ({alloc, dequeue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry payload, written at dispatch and merged at completion
    always_ff @(posedge clk) begin
        if (alloc) begin
            entries[tail_ptr].pc          <= dispatch.pc;
            entries[tail_ptr].instr_class <= dispatch.instr_class;
            entries[tail_ptr].special     <= dispatch.special;
            entries[tail_ptr].reg_dest    <= dispatch.reg_dest;
            entries[tail_ptr].csr_write   <= dispatch.csr_write;
            entries[tail_ptr].csr_read    <= dispatch.csr_read;
            entries[tail_ptr].csr_sel     <= dispatch.csr_sel;
            entries[tail_ptr].branch_pred <= dispatch.branch_pred;
            entries[tail_ptr].ready       <= 1'b0;
            entries[tail_ptr].tag         <= tail_ptr;
        end
        if (merge) begin
            entries[done.tag].value         <= done.value;
            entries[done.tag].destination   <= done.destination;
            entries[done.tag].branch_result <= done.branch_result;
            entries[done.tag].exception     <= done.exception;
            entries[done.tag].mcause        <= done.mcause;
            entries[done.tag].ready         <= 1'b1;
        end
    end

endmodule

/* commit_unit.sv */
////////////////////////////////////////
// Pure combinational, one retirement per cycle
// Ecall cause is refined by the privilege owner
////////////////////////////////////////
`include "rob_defines.svh"

module commit_unit (
    input  rob_pkg::rob_entry_t head,
    input  logic                head_ready,
    input  logic                empty,
    input  logic                illegal_access,
    input  logic [`XLEN-1:0]    mtvec,
    input  logic [`XLEN-1:0]    mepc,
    input  logic                store_ack,
    output rob_pkg::commit_t    commit,
    output logic                dequeue,
    output logic                flush,
    output logic                store_req,
    output logic                redirect_valid,
    output logic [`XLEN-1:0]    redirect_pc
);
    import rob_pkg::*;

    logic       trap;
    logic [7:0] trap_cause;

    always_comb begin
        commit         = '0;
        commit.rd      = head.reg_dest;
        commit.csr_sel = head.csr_sel;
        commit.mepc    = head.pc;
        dequeue        = 1'b0;
        flush          = 1'b0;
        store_req      = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        trap           = 1'b0;
        trap_cause     = '0;

        if (head_ready && !empty) begin
            if (head.exception) begin
                trap       = 1'b1;   // Reported by execution
                trap_cause = head.mcause;
            end else if (head.instr_class == CLS_BRANCH) begin
                dequeue = 1'b1;
                if (head.branch_pred != head.branch_result) begin
                    flush          = 1'b1;
                    redirect_valid = 1'b1;
                    redirect_pc    = head.branch_result ? head.destination
                                                        : head.pc + `XLEN'd4;
                end
            end else if (head.instr_class == CLS_STORE) begin
                store_req = 1'b1;
                dequeue   = store_ack;   // Hold the head until the bus is done
            end else if (head.special[0]) begin
                trap = 1'b1;
                // User variant here, promoted in machine mode by arch_state
                trap_cause = (head.special == SP_EBREAK) ? MCAUSE_BREAK : MCAUSE_ECALL_U;
            end else if (head.special == SP_MRET) begin
                if (illegal_access) begin
                    trap       = 1'b1;
                    trap_cause = MCAUSE_ILLEGAL;
                end else begin
                    dequeue        = 1'b1;
                    flush          = 1'b1;
                    redirect_valid = 1'b1;
                    redirect_pc    = mepc;
                    commit.mret    = 1'b1;
                end
            end else if (head.csr_write) begin
                if (illegal_access) begin
                    trap       = 1'b1;
                    trap_cause = MCAUSE_ILLEGAL;
                end else begin
                    dequeue           = 1'b1;
                    commit.csr_write  = 1'b1;
                    commit.csr_data   = head.value;
                    commit.reg_write  = 1'b1;
                    commit.write_data = head.destination;   // Old CSR value
                end
            end else if (head.csr_read) begin
                dequeue           = 1'b1;
                commit.reg_write  = 1'b1;
                commit.write_data = head.destination;
            end else begin
                dequeue           = 1'b1;
                commit.reg_write  = 1'b1;
                commit.write_data = head.value;
            end

            // All traps take the same exit
            if (trap) begin
                dequeue        = 1'b1;
                flush          = 1'b1;
                redirect_valid = 1'b1;
                redirect_pc    = mtvec;
                commit.trap    = 1'b1;
                commit.mcause  = trap_cause;
            end
        end
    end

endmodule

/* arch_state.sv */
////////////////////////////////////////
// Privilege is one bit, user or machine
// Register 0 reads zero and ignores writes
////////////////////////////////////////
`include "rob_defines.svh"

module arch_state (
    input  logic                   clk,
    input  logic                   rst,
    input  rob_pkg::commit_t       commit,
    input  rob_pkg::rob_entry_t    head,
    input  logic [`REG_ADDR_W-1:0] reg_raddr,
    output logic                   illegal_access,
    output logic [`XLEN-1:0]       mtvec,
    output logic [`XLEN-1:0]       mepc,
    output logic [`XLEN-1:0]       reg_rdata
);
    import rob_pkg::*;

    logic [`XLEN-1:0] regs [32];
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mscratch;
    logic             priv_m;       // Set in machine mode
    logic [7:0]       trap_cause;

    // An ecall taken from machine mode reports its own cause
    assign trap_cause = (priv_m && commit.mcause == MCAUSE_ECALL_U) ? MCAUSE_ECALL_M
                                                                     : commit.mcause;

    assign illegal_access = !priv_m &&
                            (head.csr_write || head.csr_read || head.special == SP_MRET);

    assign reg_rdata = (reg_raddr == '0) ? '0 : regs[reg_raddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
            priv_m   <= 1'b0;   // Start in user mode
        end else begin
            if (commit.reg_write && commit.rd != '0) begin
                regs[commit.rd] <= commit.write_data;
            end
            if (commit.csr_write) begin
                case (commit.csr_sel)
                    CSR_MTVEC:    mtvec    <= commit.csr_data;
                    CSR_MEPC:     mepc     <= commit.csr_data;
                    CSR_MCAUSE:   mcause   <= commit.csr_data;
                    CSR_MSCRATCH: mscratch <= commit.csr_data;
                    default:      mscratch <= mscratch;
                endcase
            end
            if (commit.trap) begin
                mepc   <= commit.mepc;
                mcause <= {{(`XLEN-8){1'b0}}, trap_cause};
                priv_m <= 1'b1;
            end else if (commit.mret) begin
                priv_m <= 1'b0;
            end
        end
    end

endmodule

/* store_port.sv */
////////////////////////////////////////
// Single-beat Wishbone classic writes only
// store_ack comes one cycle after wb_ack
////////////////////////////////////////
`include "rob_defines.svh"

module store_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  store_req,
    input  logic [`XLEN-1:0]      addr,
    input  logic [`XLEN-1:0]      data,
    input  logic                  wb_ack,
    output logic                  store_ack,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [`XLEN-1:0]      wb_adr,
    output logic [`XLEN-1:0]      wb_dat_o,
    output logic [`XLEN/8-1:0]    wb_sel
);
    import rob_pkg::*;

    store_state_e state;

    assign wb_cyc    = (state == SP_BUS);
    assign wb_stb    = wb_cyc;
    assign wb_we     = wb_cyc;
    assign wb_sel    = '1;            // Full-word stores
    assign store_ack = (state == SP_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SP_IDLE;
        end else begin
            case (state)
                SP_IDLE: if (store_req) state <= SP_BUS;
                SP_BUS:  if (wb_ack) state <= SP_DONE;
                SP_DONE: state <= SP_IDLE;   // Head store leaves the ROB here
                default: state <= SP_IDLE;
            endcase
        end
    end

    // Capture the head store when the cycle starts
    always_ff @(posedge clk) begin
        if (state == SP_IDLE && store_req) begin
            wb_adr   <= addr;
            wb_dat_o <= data;
        end
    end

endmodule

/* commit_top.sv */
////////////////////////////////////////
// Retirement end of the core, no fetch or issue
// Stores leave only through the Wishbone port
////////////////////////////////////////
`include "rob_defines.svh"

module commit_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dispatch_valid,
    input  rob_pkg::dispatch_t     dispatch,
    output logic                   dispatch_ready,
    output logic [`ROB_TAG_W-1:0]  dispatch_tag,
    input  logic                   done_valid,
    input  rob_pkg::done_t         done,
    input  logic [`REG_ADDR_W-1:0] reg_raddr,
    output logic [`XLEN-1:0]       reg_rdata,
    output logic                   redirect_valid,
    output logic [`XLEN-1:0]       redirect_pc,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output logic [`XLEN-1:0]       wb_adr,
    output logic [`XLEN-1:0]       wb_dat_o,
    output logic [`XLEN/8-1:0]     wb_sel,
    input  logic                   wb_ack
);
    import rob_pkg::*;

    rob_entry_t       head;
    logic             head_ready;
    logic             empty;
    logic             dequeue;
    logic             flush;
    commit_t          commit;
    logic             illegal_access;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic             store_req;
    logic             store_ack;

    reorder_buffer u_rob (.*);

    commit_unit u_commit (.*);

    arch_state u_arch (.*);

    // Store address and data sit in the head entry
    store_port u_store (
        .addr (head.destination),
        .data (head.value),
        .*
    );

endmodule

/* tb_commit.sv */
////////////////////////////////////////
// Plays fetch, issue and execution through the ports
// Tests run in order and share the CSR state
////////////////////////////////////////
`include "rob_defines.svh"

module tb_commit;
    timeunit 1ns;
    timeprecision 1ps;

    import rob_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int STIM_DELAY      = 10;
    localparam int MAX_WAIT        = 40;    // Cycles allowed for one handshake
    localparam int TEST_LEN_CYCLES = 420;   // Six tests of under 70 cycles each
    localparam int WATCHDOG_CYCLES = 2 * TEST_LEN_CYCLES;

    logic                   clk;
    logic                   rst;
    logic                   dispatch_valid;
    dispatch_t              dispatch;
    logic                   dispatch_ready;
    logic [`ROB_TAG_W-1:0]  dispatch_tag;
    logic                   done_valid;
    done_t                  done;
    logic [`REG_ADDR_W-1:0] reg_raddr;
    logic [`XLEN-1:0]       reg_rdata;
    logic                   redirect_valid;
    logic [`XLEN-1:0]       redirect_pc;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`XLEN-1:0]       wb_adr;
    logic [`XLEN-1:0]       wb_dat_o;
    logic [`XLEN/8-1:0]     wb_sel;
    logic                   wb_ack;

    int               error_count = 0;
    int               check_count = 0;
    int               wr_count    = 0;     // Bus writes seen by the slave
    int               ack_wait    = 0;
    bit               in_cycle    = 0;
    logic [`XLEN-1:0] wr_adr_q [$];
    logic [`XLEN-1:0] wr_dat_q [$];
    logic [`XLEN-1:0] redir_q [$];

    commit_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Wishbone slave with 0 to 3 wait cycles before the ack
    initial begin
        wb_ack = 1'b0;
        forever begin
            @(posedge clk);
            #STIM_DELAY;
            if (wb_ack) begin
                wb_ack = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!in_cycle) begin
                    in_cycle = 1'b1;
                    ack_wait = $urandom_range(3, 0);
                end
                if (ack_wait == 0) begin
                    wb_ack   = 1'b1;
                    in_cycle = 1'b0;
                    wr_count++;
                    wr_adr_q.push_back(wb_adr);
                    wr_dat_q.push_back(wb_dat_o);
                    check_value("wb_we", 32'(wb_we), 32'h1);
                    check_value("wb_sel", 32'(wb_sel), 32'h0000_000f);
                    $display("Bus write adr=%h dat=%h sel=%h", wb_adr, wb_dat_o, wb_sel);
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    // Redirect pulses sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && redirect_valid) begin
            redir_q.push_back(redirect_pc);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("Test failures found");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #STIM_DELAY;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("[ERROR] %s: expected 0x%08h, got 0x%08h", name, exp, got);
        end
    endtask

    function automatic dispatch_t make_op(input logic [31:0] pc, input instr_class_e cls,
                                          input special_e sp, input logic [4:0] rd,
                                          input logic csr_w, input logic pred);
        dispatch_t d;
        d             = '0;
        d.pc          = pc;
        d.instr_class = cls;
        d.special     = sp;
        d.reg_dest    = rd;
        d.csr_write   = csr_w;
        d.csr_sel     = CSR_MTVEC;    // Only mtvec is exercised
        d.branch_pred = pred;
        return d;
    endfunction

    task automatic dispatch_op(input dispatch_t op, output logic [`ROB_TAG_W-1:0] tag);
        int waited = 0;
        while (!dispatch_ready && waited < MAX_WAIT) begin
            next_cycle();
            waited++;
        end
        check_count++;
        assert (dispatch_ready) else begin
            error_count++;
            $display("Dispatch stalled because the reorder buffer stayed full");
        end
        dispatch_valid = 1'b1;
        dispatch       = op;
        tag            = dispatch_tag;
        next_cycle();
        dispatch_valid = 1'b0;
    endtask

    task automatic complete_op(input logic [`ROB_TAG_W-1:0] tag, input logic [31:0] value,
                               input logic [31:0] dest, input logic taken,
                               input logic exc, input logic [7:0] cause);
        done_valid         = 1'b1;
        done.tag           = tag;
        done.value         = value;
        done.destination   = dest;
        done.branch_result = taken;
        done.exception     = exc;
        done.mcause        = cause;
        next_cycle();
        done_valid = 1'b0;
    endtask

    task automatic expect_reg(input logic [4:0] addr, input logic [31:0] exp);
        reg_raddr = addr;
        @(negedge clk);
        check_value($sformatf("reg_rdata[x%0d]", addr), reg_rdata, exp);
        next_cycle();
    endtask

    // Polls the read port until the register holds the value
    task automatic wait_reg(input logic [4:0] addr, input logic [31:0] exp);
        bit found = 0;
        reg_raddr = addr;
        for (int n = 0; n < MAX_WAIT && !found; n++) begin
            @(negedge clk);
            found = (reg_rdata === exp);
        end
        check_count++;
        assert (found) else begin
            error_count++;
            $display("Timed out waiting for register x%0d to reach 0x%08h", addr, exp);
        end
        next_cycle();
    endtask

    task automatic wait_redirect(input logic [31:0] exp_pc);
        for (int n = 0; n < MAX_WAIT && redir_q.size() == 0; n++) begin
            @(posedge clk);
        end
        check_count++;
        assert (redir_q.size() > 0) else begin
            error_count++;
            $display("Timed out waiting for a redirect to 0x%08h", exp_pc);
        end
        if (redir_q.size() > 0) begin
            check_value("redirect_pc", redir_q.pop_front(), exp_pc);
        end
        next_cycle();
    endtask

    task automatic retire_in_order();
        logic [`ROB_TAG_W-1:0] tags [9];
        logic [4:0]            rds [9];
        logic [31:0]           vals [9];
        int                    order [9];
        int                    j;
        int                    tmp;
        for (int i = 0; i < 8; i++) begin
            rds[i]  = 5'(i + 1);
            vals[i] = 32'h1000_0000 + 32'h111 * (i + 1);
        end
        rds[8]  = 5'd3;              // Younger write to x3 wins
        vals[8] = 32'hcafe_0003;
        for (int i = 0; i < 9; i++) begin
            dispatch_op(make_op(32'h100 + 4 * i, CLS_REG, SP_NONE, rds[i], 0, 0), tags[i]);
            order[i] = i;
        end
        for (int i = 8; i > 0; i--) begin
            j        = $urandom_range(i, 0);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 9; i++) begin
            complete_op(tags[order[i]], vals[order[i]], '0, 0, 0, '0);
        end
        wait_reg(5'd3, vals[8]);
        for (int i = 0; i < 8; i++) begin
            if (i != 2) expect_reg(rds[i], vals[i]);
        end
        expect_reg(5'd3, vals[8]);
    endtask

    task automatic store_between_ops();
        logic [`ROB_TAG_W-1:0] tag_a;
        logic [`ROB_TAG_W-1:0] tag_s;
        logic [`ROB_TAG_W-1:0] tag_b;
        int                    wr_start;
        bit                    seen = 0;
        wr_start = wr_count;
        dispatch_op(make_op(32'h180, CLS_REG, SP_NONE, 5'd10, 0, 0), tag_a);
        dispatch_op(make_op(32'h184, CLS_STORE, SP_NONE, 5'd0, 0, 0), tag_s);
        dispatch_op(make_op(32'h188, CLS_REG, SP_NONE, 5'd11, 0, 0), tag_b);
        reg_raddr = 5'd11;
        complete_op(tag_b, 32'hbbbb_0011, '0, 0, 0, '0);
        complete_op(tag_s, 32'hdead_beef, 32'h8000_0040, 0, 0, '0);
        complete_op(tag_a, 32'haaaa_0010, '0, 0, 0, '0);
        // The younger op stays invisible up to and including the ack cycle
        for (int n = 0; n < MAX_WAIT && !seen; n++) begin
            @(negedge clk);
            seen = (wr_count != wr_start);
            check_value("reg_rdata[x11] before ack", reg_rdata, 32'h0);
        end
        check_count++;
        assert (seen) else begin
            error_count++;
            $display("Timed out waiting for the store on the bus");
        end
        next_cycle();
        wait_reg(5'd11, 32'hbbbb_0011);
        check_value("bus write count", wr_count - wr_start, 1);
        if (wr_count > wr_start) begin
            check_value("wb_adr", wr_adr_q[wr_adr_q.size() - 1], 32'h8000_0040);
            check_value("wb_dat_o", wr_dat_q[wr_dat_q.size() - 1], 32'hdead_beef);
        end
        expect_reg(5'd10, 32'haaaa_0010);
    endtask

    task automatic branch_flush();
        logic [`ROB_TAG_W-1:0] tag_br;
        logic [`ROB_TAG_W-1:0] tag_y1;
        logic [`ROB_TAG_W-1:0] tag_y2;
        logic [`ROB_TAG_W-1:0] tag_m;
        redir_q.delete();
        // Correctly predicted taken branch
        dispatch_op(make_op(32'h200, CLS_BRANCH, SP_NONE, 5'd0, 0, 1), tag_br);
        dispatch_op(make_op(32'h204, CLS_REG, SP_NONE, 5'd12, 0, 0), tag_m);
        complete_op(tag_br, '0, 32'h300, 1, 0, '0);
        complete_op(tag_m, 32'h0000_0c12, '0, 0, 0, '0);
        wait_reg(5'd12, 32'h0000_0c12);
        check_count++;
        assert (redir_q.size() == 0) else begin
            error_count++;
            $display("A correctly predicted branch caused a redirect");
        end
        // Predicted not taken but taken
        dispatch_op(make_op(32'h400, CLS_BRANCH, SP_NONE, 5'd0, 0, 0), tag_br);
        dispatch_op(make_op(32'h404, CLS_REG, SP_NONE, 5'd13, 0, 0), tag_y1);
        dispatch_op(make_op(32'h408, CLS_REG, SP_NONE, 5'd14, 0, 0), tag_y2);
        complete_op(tag_br, '0, 32'h800, 1, 0, '0);
        wait_redirect(32'h800);
        complete_op(tag_y1, 32'h0000_0d13, '0, 0, 0, '0);   // Flushed so it is dropped
        complete_op(tag_y2, 32'h0000_0d14, '0, 0, 0, '0);
        dispatch_op(make_op(32'h800, CLS_REG, SP_NONE, 5'd15, 0, 0), tag_m);
        complete_op(tag_m, 32'h0000_0f15, '0, 0, 0, '0);
        wait_reg(5'd15, 32'h0000_0f15);
        expect_reg(5'd13, 32'h0);
        expect_reg(5'd14, 32'h0);
    endtask

    task automatic csr_privilege();
        logic [`ROB_TAG_W-1:0] tag;
        redir_q.delete();
        // User-mode CSR write traps to the reset mtvec
        dispatch_op(make_op(32'h500, CLS_SYSTEM, SP_NONE, 5'd16, 1, 0), tag);
        complete_op(tag, 32'h0000_1000, 32'h0000_5555, 0, 0, '0);
        wait_redirect(32'h0);
        expect_reg(5'd16, 32'h0);
        dispatch_op(make_op(32'h600, CLS_SYSTEM, SP_ECALL, 5'd0, 0, 0), tag);
        complete_op(tag, '0, '0, 0, 0, '0);
        wait_redirect(32'h0);
        // Preload x17 so the old mtvec value is visible
        dispatch_op(make_op(32'h000, CLS_REG, SP_NONE, 5'd17, 0, 0), tag);
        complete_op(tag, 32'hffff_ffff, '0, 0, 0, '0);
        wait_reg(5'd17, 32'hffff_ffff);
        dispatch_op(make_op(32'h004, CLS_SYSTEM, SP_NONE, 5'd17, 1, 0), tag);
        complete_op(tag, 32'h0000_4000, 32'h0, 0, 0, '0);
        wait_reg(5'd17, 32'h0);
        check_count++;
        assert (redir_q.size() == 0) else begin
            error_count++;
            $display("A machine-mode CSR write caused a redirect");
        end
        dispatch_op(make_op(32'h700, CLS_SYSTEM, SP_EBREAK, 5'd0, 0, 0), tag);
        complete_op(tag, '0, '0, 0, 0, '0);
        wait_redirect(32'h0000_4000);
    endtask

    task automatic trap_and_return();
        logic [`ROB_TAG_W-1:0] tag;
        redir_q.delete();
        // Machine mode after the ebreak and mepc holds its pc
        dispatch_op(make_op(32'h900, CLS_SYSTEM, SP_MRET, 5'd0, 0, 0), tag);
        complete_op(tag, '0, '0, 0, 0, '0);
        wait_redirect(32'h700);
        dispatch_op(make_op(32'ha00, CLS_SYSTEM, SP_ECALL, 5'd0, 0, 0), tag);
        complete_op(tag, '0, '0, 0, 0, '0);
        wait_redirect(32'h0000_4000);
        dispatch_op(make_op(32'h4000, CLS_SYSTEM, SP_MRET, 5'd0, 0, 0), tag);
        complete_op(tag, '0, '0, 0, 0, '0);
        wait_redirect(32'ha00);
        // Back in user mode, so mret is illegal
        dispatch_op(make_op(32'ha04, CLS_SYSTEM, SP_MRET, 5'd0, 0, 0), tag);
        complete_op(tag, '0, '0, 0, 0, '0);
        wait_redirect(32'h0000_4000);
    endtask

    task automatic reported_exception();
        logic [`ROB_TAG_W-1:0] tag_x;
        logic [`ROB_TAG_W-1:0] tag_y;
        logic [`ROB_TAG_W-1:0] tag_m;
        redir_q.delete();
        dispatch_op(make_op(32'hb00, CLS_REG, SP_NONE, 5'd18, 0, 0), tag_x);
        dispatch_op(make_op(32'hb04, CLS_REG, SP_NONE, 5'd19, 0, 0), tag_y);
        complete_op(tag_y, 32'h0000_0e19, '0, 0, 0, '0);     // Younger finishes first
        complete_op(tag_x, 32'h0000_0e18, '0, 0, 1, 8'd5);
        wait_redirect(32'h0000_4000);
        dispatch_op(make_op(32'h4000, CLS_REG, SP_NONE, 5'd20, 0, 0), tag_m);
        complete_op(tag_m, 32'h0000_0e20, '0, 0, 0, '0);
        wait_reg(5'd20, 32'h0000_0e20);
        expect_reg(5'd18, 32'h0);
        expect_reg(5'd19, 32'h0);
    endtask

    initial begin
        void'($urandom(32'hc9e9));
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        done_valid     = 1'b0;
        done           = '0;
        reg_raddr      = '0;
        repeat (2) @(posedge clk);
        #STIM_DELAY;
        rst = 1'b0;
        check_value("dispatch_ready", 32'(dispatch_ready), 32'h1);
        check_value("redirect_valid", 32'(redirect_valid), 32'h0);
        check_value("wb_cyc", 32'(wb_cyc), 32'h0);
        check_value("wb_stb", 32'(wb_stb), 32'h0);
        retire_in_order();
        store_between_ops();
        branch_flush();
        csr_privilege();
        trap_and_return();
        reported_exception();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
rob_pkg.sv
reorder_buffer.sv
commit_unit.sv
arch_state.sv
store_port.sv
commit_top.sv
tb_commit.sv
